// File: verilog/md_consts.svh
`ifndef MD_CONSTS_SVH
`define MD_CONSTS_SVH

// Operand width and width of each HI/LO half
`define MD_WIDTH        32

`define MD_OP_WIDTH     3

// Operation codes as seen on the op port
`define MD_OP_MULT      3'd0
`define MD_OP_MULTU     3'd1
`define MD_OP_DIV       3'd2
`define MD_OP_DIVU      3'd3
`define MD_OP_MTHI      3'd4
`define MD_OP_MTLO      3'd5
`define MD_OP_MFHI      3'd6
`define MD_OP_MFLO      3'd7

`define MD_MUL_LATENCY  2       // Operand stage plus product stage

`define MD_DIV_CYCLES   32      // One quotient bit per iteration

`endif

// File: verilog/md_pkg.sv
`default_nettype none

`include "md_consts.svh"

package md_pkg;

    // A 64-bit HI/LO word. The multiplier writes it whole, the divider
    // and the register pair work on the two halves
    typedef union packed {
        logic [2*`MD_WIDTH-1:0] product;    // Full 64-bit product
        struct packed {
            logic [`MD_WIDTH-1:0] hi;       // Upper word, remainder on divides
            logic [`MD_WIDTH-1:0] lo;       // Lower word, quotient on divides
        } halves;
    } hilo_u;

endpackage

`default_nettype wire

// File: verilog/md_issue.sv
`default_nettype none

`include "md_consts.svh"

module md_issue (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    op_valid,
    input  logic [`MD_OP_WIDTH-1:0] op,
    input  logic                    mul_pending,
    input  logic                    div_busy,
    output logic                    mul_start,
    output logic                    mul_signed,
    output logic                    div_start,
    output logic                    div_signed,
    output logic                    mt_hi_we,
    output logic                    mt_lo_we,
    output logic                    rd_req,
    output logic                    rd_sel_hi,
    output logic                    busy
);

    logic is_mul;

    assign is_mul = (op == `MD_OP_MULT) || (op == `MD_OP_MULTU);

    // One strobe per accepted operation
    always_comb begin
        mul_start = 1'b0;
        div_start = 1'b0;
        mt_hi_we  = 1'b0;
        mt_lo_we  = 1'b0;
        rd_req    = 1'b0;
        if (op_valid) begin
            case (op)
                `MD_OP_MULT,
                `MD_OP_MULTU: mul_start = 1'b1;
                `MD_OP_DIV,
                `MD_OP_DIVU:  div_start = 1'b1;
                `MD_OP_MTHI:  mt_hi_we  = 1'b1;
                `MD_OP_MTLO:  mt_lo_we  = 1'b1;
                `MD_OP_MFHI,
                `MD_OP_MFLO:  rd_req    = 1'b1;
                default:      rd_req    = 1'b0;
            endcase
        end
    end

    assign mul_signed = (op == `MD_OP_MULT);   // MULTU is the unsigned twin
    assign div_signed = (op == `MD_OP_DIV);
    assign rd_sel_hi  = (op == `MD_OP_MFHI);   // Else MFLO

    // High while a product is still on its way to HI/LO or a divide runs
    assign busy = mul_pending || div_busy;

    // Nothing may be issued into a running divide
    a_no_op_during_div: assert property (
        @(posedge clk) disable iff (rst)
        !(op_valid && div_busy)
    ) else $error("operation issued while divider busy");

    // Only further multiplies may stack up behind pending ones
    a_only_mul_when_busy: assert property (
        @(posedge clk) disable iff (rst)
        (op_valid && busy) |-> is_mul
    ) else $error("non multiply operation issued while busy");

endmodule

`default_nettype wire

// File: verilog/md_multiplier.sv
`default_nettype none

`include "md_consts.svh"

module md_multiplier
    import md_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 mul_start,
    input  logic                 mul_signed,
    input  logic [`MD_WIDTH-1:0] rs_value,
    input  logic [`MD_WIDTH-1:0] rt_value,
    output logic                 mul_done,
    output logic                 mul_pending,
    output hilo_u                mul_result
);

    localparam int W = `MD_WIDTH;

    logic                  s1_valid;
    logic                  s2_valid;
    logic signed [W:0]     a_q;         // Operands widened by one sign bit
    logic signed [W:0]     b_q;
    logic signed [2*W+1:0] prod_full;
    hilo_u                 prod_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= mul_start;
            s2_valid <= s1_valid;
        end
    end

    // Stage 1, extension bit is zero for MULTU
    always_ff @(posedge clk) begin
        if (mul_start) begin
            a_q <= {mul_signed & rs_value[W-1], rs_value};
            b_q <= {mul_signed & rt_value[W-1], rt_value};
        end
    end

    assign prod_full = a_q * b_q;    // Low 64 bits right for both signednesses

    // Stage 2
    always_ff @(posedge clk) begin
        if (s1_valid) prod_q.product <= prod_full[2*W-1:0];
    end

    assign mul_result  = prod_q;
    assign mul_done    = s2_valid;
    assign mul_pending = s1_valid || s2_valid;

endmodule

`default_nettype wire

// File: verilog/md_divider.sv
`default_nettype none

`include "md_consts.svh"

module md_divider
    import md_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 div_start,
    input  logic                 div_signed,
    input  logic [`MD_WIDTH-1:0] rs_value,
    input  logic [`MD_WIDTH-1:0] rt_value,
    output logic                 div_busy,
    output logic                 div_done,
    output hilo_u                div_result
);

    localparam int W     = `MD_WIDTH;
    localparam int CNT_W = $clog2(`MD_DIV_CYCLES + 1);

    logic             busy_q;
    logic [CNT_W-1:0] cnt_q;
    logic [W-1:0]     rem_q;        // Partial remainder
    logic [W-1:0]     quo_q;        // Dividend bits out, quotient bits in
    logic [W-1:0]     dsr_q;        // Divisor magnitude
    logic             quo_neg_q;
    logic             rem_neg_q;
    logic [W-1:0]     rs_mag;
    logic [W-1:0]     rt_mag;
    logic [W:0]       shifted;
    logic [W:0]       diff;
    logic             iterate;

    assign rs_mag = (div_signed && rs_value[W-1]) ? -rs_value : rs_value;
    assign rt_mag = (div_signed && rt_value[W-1]) ? -rt_value : rt_value;

    assign iterate  = busy_q && (cnt_q != CNT_W'(`MD_DIV_CYCLES));
    assign div_done = busy_q && (cnt_q == CNT_W'(`MD_DIV_CYCLES));
    assign div_busy = busy_q;   // Still high in the write-back cycle

    // Trial subtract, top bit set means it did not fit
    assign shifted = {rem_q, quo_q[W-1]};
    assign diff    = shifted - {1'b0, dsr_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (div_start) begin
            busy_q <= 1'b1;
            cnt_q  <= '0;
        end else if (div_done) begin
            busy_q <= 1'b0;
        end else if (iterate) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (div_start) begin
            rem_q     <= '0;
            quo_q     <= rs_mag;
            dsr_q     <= rt_mag;
            quo_neg_q <= div_signed && (rs_value[W-1] ^ rt_value[W-1]);
            rem_neg_q <= div_signed && rs_value[W-1];
        end else if (iterate) begin
            if (!diff[W]) begin
                rem_q <= diff[W-1:0];
                quo_q <= {quo_q[W-2:0], 1'b1};
            end else begin
                rem_q <= shifted[W-1:0];   // Restore
                quo_q <= {quo_q[W-2:0], 1'b0};
            end
        end
    end

    // Quotient truncates toward zero, remainder follows the dividend
    always_comb begin
        div_result.halves.hi = rem_neg_q ? -rem_q : rem_q;
        div_result.halves.lo = quo_neg_q ? -quo_q : quo_q;
    end

    a_no_restart: assert property (
        @(posedge clk) disable iff (rst)
        !(div_start && div_busy)
    ) else $error("divide started while divider busy");

endmodule

`default_nettype wire

// File: verilog/hilo_regs.sv
`default_nettype none

`include "md_consts.svh"

module hilo_regs
    import md_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 mul_done,
    input  hilo_u                mul_result,
    input  logic                 div_done,
    input  hilo_u                div_result,
    input  logic                 mt_hi_we,
    input  logic                 mt_lo_we,
    input  logic [`MD_WIDTH-1:0] rs_value,
    input  logic                 rd_req,
    input  logic                 rd_sel_hi,
    output logic                 rd_valid,
    output logic [`MD_WIDTH-1:0] rd_data
);

    logic [`MD_WIDTH-1:0] hi_q;
    logic [`MD_WIDTH-1:0] lo_q;

    // Product beats move-to, move-to beats divide result
    always_ff @(posedge clk) begin
        if (rst) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (mul_done) begin
            hi_q <= mul_result.halves.hi;
            lo_q <= mul_result.halves.lo;
        end else begin
            if (mt_hi_we)      hi_q <= rs_value;
            else if (div_done) hi_q <= div_result.halves.hi;    // Remainder
            if (mt_lo_we)      lo_q <= rs_value;
            else if (div_done) lo_q <= div_result.halves.lo;    // Quotient
        end
    end

    // Read port, one cycle after the request
    always_ff @(posedge clk) begin
        if (rst) rd_valid <= 1'b0;
        else     rd_valid <= rd_req;
    end

    always_ff @(posedge clk) begin
        if (rd_req) rd_data <= rd_sel_hi ? hi_q : lo_q;
    end

    // The two units never finish in the same cycle
    a_one_result: assert property (
        @(posedge clk) disable iff (rst)
        !(mul_done && div_done)
    ) else $error("multiply and divide results collide");

endmodule

`default_nettype wire

// File: verilog/md_unit.sv
`default_nettype none

`include "md_consts.svh"

module md_unit
    import md_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    op_valid,
    input  logic [`MD_OP_WIDTH-1:0] op,
    input  logic [`MD_WIDTH-1:0]    rs_value,
    input  logic [`MD_WIDTH-1:0]    rt_value,
    output logic                    busy,
    output logic                    rd_valid,
    output logic [`MD_WIDTH-1:0]    rd_data
);

    logic  mul_start;
    logic  mul_signed;
    logic  mul_done;
    logic  mul_pending;
    hilo_u mul_result;
    logic  div_start;
    logic  div_signed;
    logic  div_busy;
    logic  div_done;
    hilo_u div_result;
    logic  mt_hi_we;
    logic  mt_lo_we;
    logic  rd_req;
    logic  rd_sel_hi;

    md_issue u_issue (
        .clk         (clk),
        .rst         (rst),
        .op_valid    (op_valid),
        .op          (op),
        .mul_pending (mul_pending),     // Hazard from the multiplier pipe
        .div_busy    (div_busy),
        .mul_start   (mul_start),
        .mul_signed  (mul_signed),
        .div_start   (div_start),
        .div_signed  (div_signed),
        .mt_hi_we    (mt_hi_we),
        .mt_lo_we    (mt_lo_we),
        .rd_req      (rd_req),
        .rd_sel_hi   (rd_sel_hi),
        .busy        (busy)
    );

    md_multiplier u_mul (
        .clk         (clk),
        .rst         (rst),
        .mul_start   (mul_start),
        .mul_signed  (mul_signed),
        .rs_value    (rs_value),
        .rt_value    (rt_value),
        .mul_done    (mul_done),
        .mul_pending (mul_pending),
        .mul_result  (mul_result)
    );

    md_divider u_div (
        .clk         (clk),
        .rst         (rst),
        .div_start   (div_start),
        .div_signed  (div_signed),
        .rs_value    (rs_value),        // Dividend
        .rt_value    (rt_value),        // Divisor
        .div_busy    (div_busy),
        .div_done    (div_done),
        .div_result  (div_result)
    );

    hilo_regs u_hilo (
        .clk         (clk),
        .rst         (rst),
        .mul_done    (mul_done),
        .mul_result  (mul_result),
        .div_done    (div_done),
        .div_result  (div_result),
        .mt_hi_we    (mt_hi_we),
        .mt_lo_we    (mt_lo_we),
        .rs_value    (rs_value),        // Move-to data
        .rd_req      (rd_req),
        .rd_sel_hi   (rd_sel_hi),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data)
    );

endmodule

`default_nettype wire

// File: bench/md_unit_tb.sv
`default_nettype none

`include "md_consts.svh"

module md_unit_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_OPS    = 88;     // Sum of the operations issued below

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    op_valid;
    logic [`MD_OP_WIDTH-1:0] op;
    logic [`MD_WIDTH-1:0]    rs_value;
    logic [`MD_WIDTH-1:0]    rt_value;
    logic                    busy;
    logic                    rd_valid;
    logic [`MD_WIDTH-1:0]    rd_data;

    logic [`MD_WIDTH-1:0]    hi_m = '0;     // Expected HI/LO
    logic [`MD_WIDTH-1:0]    lo_m = '0;
    logic [`MD_WIDTH-1:0]    exp_rd = '0;
    logic                    rd_accept;
    logic                    mul_accept;
    logic                    div_accept;

    md_unit u_md_unit (
        .clk      (clk),
        .rst      (rst),
        .op_valid (op_valid),
        .op       (op),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .busy     (busy),
        .rd_valid (rd_valid),
        .rd_data  (rd_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    assign rd_accept  = op_valid && (op == `MD_OP_MFHI || op == `MD_OP_MFLO);
    assign mul_accept = op_valid && (op == `MD_OP_MULT || op == `MD_OP_MULTU);
    assign div_accept = op_valid && (op == `MD_OP_DIV || op == `MD_OP_DIVU);

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1);
    endtask

    a_rd_data: assert property (@(posedge clk) disable iff (rst) rd_valid |-> rd_data == exp_rd)
        else abort_run($sformatf("error rd_data expected %h got %h", exp_rd, rd_data));

    // One pulse, exactly one cycle after each read is taken
    a_rd_pulse: assert property (@(posedge clk) disable iff (rst) rd_valid == $past(rd_accept))
        else abort_run("rd_valid did not follow the read request by one cycle");

    // Product is not in HI/LO before two edges have passed
    a_mul_busy: assert property (@(posedge clk) disable iff (rst)
        ($past(mul_accept) || $past(mul_accept, 2)) |-> busy)
        else abort_run("busy dropped while a multiply was still in flight");

    a_div_busy: assert property (@(posedge clk) disable iff (rst) $past(div_accept) |-> busy)
        else abort_run("busy not raised after a divide was accepted");

    // Reference HI/LO, advanced as each operation is issued
    task automatic track_op(input logic [2:0] code, input logic [31:0] a, input logic [31:0] b);
        logic [63:0] p;
        case (code)
            `MD_OP_MULT:  p = longint'($signed(a)) * longint'($signed(b));
            `MD_OP_MULTU: p = {32'd0, a} * {32'd0, b};
            default:      p = {hi_m, lo_m};
        endcase
        {hi_m, lo_m} = p;
        case (code)
            `MD_OP_DIV: begin
                lo_m = $signed(a) / $signed(b);
                hi_m = $signed(a) % $signed(b);    // Sign of the dividend
            end
            `MD_OP_DIVU: begin
                lo_m = a / b;
                hi_m = a % b;
            end
            `MD_OP_MTHI: hi_m = a;
            `MD_OP_MTLO: lo_m = a;
            `MD_OP_MFHI: exp_rd = hi_m;
            `MD_OP_MFLO: exp_rd = lo_m;
            default: ;
        endcase
    endtask

    // Called 2 ns after a rising edge, returns at the same point one cycle later
    task automatic issue_op(input logic [2:0] code, input logic [31:0] a, input logic [31:0] b);
        op_valid = 1'b1;
        op       = code;
        rs_value = a;
        rt_value = b;
        track_op(code, a, b);
        @(posedge clk);
        #2;
        op_valid = 1'b0;
    endtask

    task automatic wait_idle(output int cycles);
        cycles = 0;
        while (busy) begin
            @(posedge clk);
            #2;
            cycles++;
        end
    endtask

    task automatic read_both();
        issue_op(`MD_OP_MFHI, 32'd0, 32'd0);
        @(posedge clk);                         // Let the check edge pass
        #2;
        issue_op(`MD_OP_MFLO, 32'd0, 32'd0);
        @(posedge clk);
        #2;
    endtask

    initial begin
        #(NUM_OPS * 40 * CLK_PERIOD);
        abort_run("Timeout, the tests did not complete in time");
    end

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  code;
        int          n;
        int          cycles;
        void'($urandom(32));
        rst      = 1'b1;
        op_valid = 1'b0;
        op       = '0;
        rs_value = '0;
        rt_value = '0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        assert (busy === 1'b0 && rd_valid === 1'b0)
            else abort_run("busy or rd_valid not low after reset");
        read_both();
        for (int i = 0; i < 8; i++) begin       // Single multiplies
            code = ($urandom % 2 == 0) ? `MD_OP_MULT : `MD_OP_MULTU;
            issue_op(code, $urandom, $urandom);
            wait_idle(cycles);
            read_both();
        end
        for (int i = 0; i < 4; i++) begin       // Back-to-back multiplies
            n = 2 + int'($urandom % 2);
            for (int k = 0; k < n; k++) begin
                code = ($urandom % 2 == 0) ? `MD_OP_MULT : `MD_OP_MULTU;
                issue_op(code, $urandom, $urandom);
            end
            wait_idle(cycles);
            read_both();
        end
        for (int i = 0; i < 8; i++) begin       // Divides
            code = (i % 2 == 0) ? `MD_OP_DIV : `MD_OP_DIVU;
            a    = $urandom;
            b    = $urandom;
            while (b == 0 || (code == `MD_OP_DIV && a == 32'h8000_0000 && b == 32'hffff_ffff))
                b = $urandom;
            issue_op(code, a, b);
            wait_idle(cycles);
            if (cycles < `MD_DIV_CYCLES)
                abort_run($sformatf("divide ended after only %0d busy cycles", cycles));
            read_both();
        end
        for (int i = 0; i < 2; i++) begin       // Move-to, then a multiply on top
            a = $urandom;
            issue_op(`MD_OP_MTHI, a, 32'd0);
            read_both();                        // LO must still hold its old value
            issue_op(`MD_OP_MTLO, ~a, 32'd0);
            read_both();
            issue_op(`MD_OP_MULT, $urandom, $urandom);
            wait_idle(cycles);
            read_both();
        end
        repeat (2) @(posedge clk);
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+verilog
verilog/md_pkg.sv
verilog/md_issue.sv
verilog/md_multiplier.sv
verilog/md_divider.sv
verilog/hilo_regs.sv
verilog/md_unit.sv
bench/md_unit_tb.sv

// File: run.sh
#!/bin/sh
# Build the multiply/divide unit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module md_unit_tb -Mdir obj_dir -o md_unit_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/md_unit_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
